// File: hdl/axis_in_config.svh
`ifndef AXIS_IN_CONFIG_SVH
`define AXIS_IN_CONFIG_SVH

// Stream beat and packed system word widths
`define AXIS_IN_TDATA_W 8
`define AXIS_IN_DATA_W 32

// FIFO depth is 2**FIFO_ADDR_W words
`define AXIS_IN_FIFO_ADDR_W 3

// Register map, word addresses
`define AXIS_IN_ADDR_ENABLE 3'd0
`define AXIS_IN_ADDR_MODE 3'd1
`define AXIS_IN_ADDR_SOFT_RESET 3'd2
`define AXIS_IN_ADDR_THRESHOLD 3'd3
`define AXIS_IN_ADDR_DATA 3'd4
`define AXIS_IN_ADDR_STATUS 3'd5
`define AXIS_IN_ADDR_NWORDS 3'd6
`define AXIS_IN_ADDR_LEVEL 3'd7

`endif

// File: hdl/axis_in_stream_pkg.sv
`include "axis_in_config.svh"

package axis_in_stream_pkg;

   // One narrow beat on the input stream
   typedef logic [`AXIS_IN_TDATA_W-1:0] beat_t;

   // One packed word on the system side
   typedef logic [`AXIS_IN_DATA_W-1:0] word_t;

   // Lane index inside a word, four lanes
   typedef logic [1:0] lane_t;

   // Accepted beat counter
   typedef logic [`AXIS_IN_DATA_W-1:0] count_t;

   // FIFO occupancy, one extra bit to reach the full depth
   typedef logic [`AXIS_IN_FIFO_ADDR_W:0] level_t;

   // Input stream payload
   typedef struct packed {
      beat_t tdata;
      logic  tlast;
   } axis_beat_t;

   // Output stage states
   typedef enum logic [1:0] {
      EMPTY = 2'd0,
      FETCH = 2'd1,
      HOLD  = 2'd2
   } drain_state_t;

endpackage

// File: hdl/axis_in_csr_pkg.sv
package axis_in_csr_pkg;

   typedef logic [2:0] csr_addr_t;

   // Register bus request, 36 bits
   typedef struct packed {
      logic                      write;
      csr_addr_t                 addr;
      axis_in_stream_pkg::word_t wdata;
   } csr_req_t;

   // Register block to datapath
   typedef struct packed {
      logic                       enable;
      // 1 selects the system stream, 0 the DATA register
      logic                       mode;
      logic                       soft_reset;
      axis_in_stream_pkg::level_t threshold;
   } csr_ctrl_t;

   // Datapath to register block
   typedef struct packed {
      logic                       empty;
      logic                       full;
      logic                       tlast_detected;
      axis_in_stream_pkg::count_t nwords;
      axis_in_stream_pkg::level_t level;
   } csr_status_t;

endpackage

// File: hdl/axis_in_csrs.sv
`timescale 1ns/1ps
`include "axis_in_config.svh"

module axis_in_csrs (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         csr_valid_i,
   input  axis_in_csr_pkg::csr_req_t    csr_req_i,
   output logic                         csr_ready_o,
   output logic                         csr_rvalid_o,
   output axis_in_stream_pkg::word_t    csr_rdata_o,
   input  axis_in_csr_pkg::csr_status_t status_i,
   input  logic                         data_valid_i,
   input  axis_in_stream_pkg::word_t    data_i,
   output logic                         data_ready_o,
   output axis_in_csr_pkg::csr_ctrl_t   ctrl_o,
   output logic                         interrupt_o
);

   localparam int LEVEL_W = $bits(axis_in_stream_pkg::level_t);
   localparam axis_in_stream_pkg::level_t DEPTH = 1 << `AXIS_IN_FIFO_ADDR_W;

   logic                       enable_q;
   logic                       mode_q;
   logic                       soft_reset_q;
   axis_in_stream_pkg::level_t threshold_q;
   logic                       data_rd;
   logic                       accept;
   logic                       wr_en;
   logic                       rd_en;
   axis_in_stream_pkg::word_t  rdata_nxt;

   // A DATA read waits here until the drain has a word
   assign data_rd = csr_valid_i && !csr_req_i.write &&
                    (csr_req_i.addr == `AXIS_IN_ADDR_DATA);
   assign csr_ready_o  = !(data_rd && !data_valid_i);
   assign accept       = csr_valid_i && csr_ready_o;
   assign wr_en        = accept && csr_req_i.write;
   assign rd_en        = accept && !csr_req_i.write;
   assign data_ready_o = data_rd && data_valid_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q     <= 1'b0;
         mode_q       <= 1'b0;
         soft_reset_q <= 1'b0;
         threshold_q  <= DEPTH;
      end else begin
         // Soft reset only lasts one cycle
         soft_reset_q <= 1'b0;
         if (wr_en) begin
            case (csr_req_i.addr)
               `AXIS_IN_ADDR_ENABLE:     enable_q     <= csr_req_i.wdata[0];
               `AXIS_IN_ADDR_MODE:       mode_q       <= csr_req_i.wdata[0];
               `AXIS_IN_ADDR_SOFT_RESET: soft_reset_q <= csr_req_i.wdata[0];
               `AXIS_IN_ADDR_THRESHOLD:  threshold_q  <= csr_req_i.wdata[LEVEL_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // Read decode
   always_comb begin
      rdata_nxt = '0;
      case (csr_req_i.addr)
         `AXIS_IN_ADDR_ENABLE:    rdata_nxt[0] = enable_q;
         `AXIS_IN_ADDR_MODE:      rdata_nxt[0] = mode_q;
         `AXIS_IN_ADDR_THRESHOLD: rdata_nxt[LEVEL_W-1:0] = threshold_q;
         `AXIS_IN_ADDR_DATA:      rdata_nxt = data_i;
         `AXIS_IN_ADDR_STATUS: begin
            rdata_nxt[2:0] = {status_i.tlast_detected, status_i.full, status_i.empty};
         end
         `AXIS_IN_ADDR_NWORDS:    rdata_nxt = status_i.nwords;
         `AXIS_IN_ADDR_LEVEL:     rdata_nxt[LEVEL_W-1:0] = status_i.level;
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         csr_rvalid_o <= 1'b0;
      end else begin
         csr_rvalid_o <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         csr_rdata_o <= rdata_nxt;
      end
   end

   assign ctrl_o = '{
      enable:     enable_q,
      mode:       mode_q,
      soft_reset: soft_reset_q,
      threshold:  threshold_q
   };

   // Level interrupt
   assign interrupt_o = (status_i.level >= threshold_q);

endmodule

// File: hdl/axis_in_pack.sv
`timescale 1ns/1ps

module axis_in_pack (
   input  logic                           clk_i,
   input  logic                           rst_i,
   input  axis_in_csr_pkg::csr_ctrl_t     ctrl_i,
   input  logic                           axis_valid_i,
   input  axis_in_stream_pkg::axis_beat_t axis_beat_i,
   output logic                           axis_ready_o,
   output logic                           push_o,
   output axis_in_stream_pkg::word_t      word_o,
   input  logic                           full_i,
   output axis_in_stream_pkg::count_t     nwords_o,
   output logic                           tlast_detected_o
);

   localparam int BEAT_W = $bits(axis_in_stream_pkg::beat_t);

   axis_in_stream_pkg::lane_t  lane_q;
   axis_in_stream_pkg::word_t  word_q;
   axis_in_stream_pkg::word_t  word_nxt;
   axis_in_stream_pkg::count_t nwords_q;
   logic                       pending_q;
   logic                       tlast_q;
   logic                       accept;
   logic                       word_done;

   // Register mode stops taking beats after the first tlast
   assign axis_ready_o = ctrl_i.enable && !pending_q && !(!ctrl_i.mode && tlast_q);
   assign accept       = axis_valid_i && axis_ready_o;
   assign word_done    = (lane_q == '1) || axis_beat_i.tlast;

   // Lane 0 starts from a cleared word, so lanes left unwritten on tlast read zero
   always_comb begin
      word_nxt = (lane_q == '0) ? '0 : word_q;
      word_nxt[lane_q*BEAT_W +: BEAT_W] = axis_beat_i.tdata;
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         word_q <= word_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.soft_reset) begin
         lane_q    <= '0;
         pending_q <= 1'b0;
      end else if (accept) begin
         if (word_done) begin
            lane_q    <= '0;
            pending_q <= 1'b1;
         end else begin
            lane_q <= lane_q + 1'b1;
         end
      end else if (push_o) begin
         pending_q <= 1'b0;
      end
   end

   // Beat count up to and including the first tlast
   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.soft_reset) begin
         nwords_q <= '0;
         tlast_q  <= 1'b0;
      end else if (accept) begin
         if (!tlast_q) begin
            nwords_q <= nwords_q + 1'b1;
         end
         if (axis_beat_i.tlast) begin
            tlast_q <= 1'b1;
         end
      end
   end

   // Completed word waits here for FIFO space
   assign push_o           = pending_q && !full_i;
   assign word_o           = word_q;
   assign nwords_o         = nwords_q;
   assign tlast_detected_o = tlast_q;

endmodule

// File: hdl/axis_in_fifo.sv
`timescale 1ns/1ps
`include "axis_in_config.svh"

module axis_in_fifo (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       clear_i,
   input  logic                       push_i,
   input  axis_in_stream_pkg::word_t  wdata_i,
   output logic                       full_o,
   input  logic                       pop_i,
   output axis_in_stream_pkg::word_t  rdata_o,
   output logic                       empty_o,
   output axis_in_stream_pkg::level_t level_o
);

   localparam int ADDR_W = `AXIS_IN_FIFO_ADDR_W;
   localparam int DEPTH = 1 << ADDR_W;

   axis_in_stream_pkg::word_t  mem_q [DEPTH];
   // Pointers carry a wrap bit on top of the address
   axis_in_stream_pkg::level_t wr_ptr_q;
   axis_in_stream_pkg::level_t rd_ptr_q;
   axis_in_stream_pkg::level_t level_q;
   logic                       pop_q;

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q[ADDR_W-1:0]] <= wdata_i;
      end
      if (pop_i) begin
         rdata_o <= mem_q[rd_ptr_q[ADDR_W-1:0]];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
         pop_q    <= 1'b0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         pop_q <= pop_i;
         // Popped word still counts while its read data is in flight
         level_q <= level_q + {{ADDR_W{1'b0}}, push_i} - {{ADDR_W{1'b0}}, pop_q};
      end
   end

   assign empty_o = (wr_ptr_q == rd_ptr_q);
   assign full_o  = (level_q == DEPTH[ADDR_W:0]);
   assign level_o = level_q;

endmodule

// File: hdl/axis_in_drain.sv
`timescale 1ns/1ps

module axis_in_drain (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  axis_in_csr_pkg::csr_ctrl_t ctrl_i,
   input  logic                       empty_i,
   output logic                       pop_o,
   input  axis_in_stream_pkg::word_t  rdata_i,
   output logic                       sys_valid_o,
   output axis_in_stream_pkg::word_t  sys_data_o,
   input  logic                       sys_ready_i,
   output logic                       data_valid_o,
   output axis_in_stream_pkg::word_t  data_o,
   input  logic                       data_ready_i
);

   axis_in_stream_pkg::drain_state_t state_q;
   axis_in_stream_pkg::drain_state_t state_nxt;
   axis_in_stream_pkg::word_t        hold_q;
   logic                             take;

   // Consumer selected by MODE
   assign take = ctrl_i.mode ? sys_ready_i : data_ready_i;

   always_comb begin
      state_nxt = state_q;
      pop_o     = 1'b0;
      case (state_q)
         axis_in_stream_pkg::EMPTY: begin
            if (!empty_i) begin
               pop_o     = 1'b1;
               state_nxt = axis_in_stream_pkg::FETCH;
            end
         end
         // FIFO read data arrives in this state
         axis_in_stream_pkg::FETCH: state_nxt = axis_in_stream_pkg::HOLD;
         axis_in_stream_pkg::HOLD: begin
            if (take) begin
               // Next word goes in flight on the hand-off
               if (!empty_i) begin
                  pop_o     = 1'b1;
                  state_nxt = axis_in_stream_pkg::FETCH;
               end else begin
                  state_nxt = axis_in_stream_pkg::EMPTY;
               end
            end
         end
         default: state_nxt = axis_in_stream_pkg::EMPTY;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.soft_reset) begin
         state_q <= axis_in_stream_pkg::EMPTY;
      end else begin
         state_q <= state_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == axis_in_stream_pkg::FETCH) begin
         hold_q <= rdata_i;
      end
   end

   assign sys_valid_o  = (state_q == axis_in_stream_pkg::HOLD) && ctrl_i.mode;
   assign data_valid_o = (state_q == axis_in_stream_pkg::HOLD) && !ctrl_i.mode;
   assign sys_data_o   = hold_q;
   assign data_o       = hold_q;

endmodule

// File: hdl/axis_in.sv
`timescale 1ns/1ps

module axis_in (
   input  logic                           clk_i,
   input  logic                           rst_i,
   // Input stream
   input  logic                           axis_tvalid_i,
   output logic                           axis_tready_o,
   input  axis_in_stream_pkg::axis_beat_t axis_beat_i,
   // System stream
   output logic                           sys_valid_o,
   input  logic                           sys_ready_i,
   output axis_in_stream_pkg::word_t      sys_data_o,
   // Register bus
   input  logic                           csr_valid_i,
   output logic                           csr_ready_o,
   input  axis_in_csr_pkg::csr_req_t      csr_req_i,
   output logic                           csr_rvalid_o,
   output axis_in_stream_pkg::word_t      csr_rdata_o,
   output logic                           interrupt_o
);

   axis_in_csr_pkg::csr_ctrl_t   ctrl;
   axis_in_csr_pkg::csr_status_t status;
   logic                         push;
   axis_in_stream_pkg::word_t    pack_word;
   logic                         fifo_full;
   logic                         fifo_empty;
   logic                         pop;
   axis_in_stream_pkg::word_t    fifo_rdata;
   axis_in_stream_pkg::level_t   fifo_level;
   axis_in_stream_pkg::count_t   nwords;
   logic                         tlast_detected;
   logic                         data_valid;
   axis_in_stream_pkg::word_t    data;
   logic                         data_ready;

   assign status = '{
      empty:          fifo_empty,
      full:           fifo_full,
      tlast_detected: tlast_detected,
      nwords:         nwords,
      level:          fifo_level
   };

   axis_in_csrs u_csrs (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .csr_valid_i  (csr_valid_i),
      .csr_req_i    (csr_req_i),
      .csr_ready_o  (csr_ready_o),
      .csr_rvalid_o (csr_rvalid_o),
      .csr_rdata_o  (csr_rdata_o),
      .status_i     (status),
      .data_valid_i (data_valid),
      .data_i       (data),
      .data_ready_o (data_ready),
      .ctrl_o       (ctrl),
      .interrupt_o  (interrupt_o)
   );

   axis_in_pack u_pack (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .ctrl_i           (ctrl),
      .axis_valid_i     (axis_tvalid_i),
      .axis_beat_i      (axis_beat_i),
      .axis_ready_o     (axis_tready_o),
      .push_o           (push),
      .word_o           (pack_word),
      .full_i           (fifo_full),
      .nwords_o         (nwords),
      .tlast_detected_o (tlast_detected)
   );

   axis_in_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .clear_i (ctrl.soft_reset),
      .push_i  (push),
      .wdata_i (pack_word),
      .full_o  (fifo_full),
      .pop_i   (pop),
      .rdata_o (fifo_rdata),
      .empty_o (fifo_empty),
      .level_o (fifo_level)
   );

   axis_in_drain u_drain (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ctrl_i       (ctrl),
      .empty_i      (fifo_empty),
      .pop_o        (pop),
      .rdata_i      (fifo_rdata),
      .sys_valid_o  (sys_valid_o),
      .sys_data_o   (sys_data_o),
      .sys_ready_i  (sys_ready_i),
      .data_valid_o (data_valid),
      .data_o       (data),
      .data_ready_i (data_ready)
   );

endmodule

// File: testbench/axis_in_checker.sv
`timescale 1ns/1ps

module axis_in_checker (
   input logic                           clk_i,
   input logic                           rst_i,
   input logic                           axis_tvalid_i,
   input logic                           axis_tready_o,
   input axis_in_stream_pkg::axis_beat_t axis_beat_i,
   input logic                           sys_valid_o,
   input logic                           sys_ready_i,
   input axis_in_stream_pkg::word_t      sys_data_o,
   input logic                           csr_valid_i,
   input logic                           csr_ready_o,
   input axis_in_csr_pkg::csr_req_t      csr_req_i,
   input logic                           csr_rvalid_o,
   input logic                           interrupt_o
);

   int unsigned fail_count = 0;
   logic        rd_accept;

   assign rd_accept = csr_valid_i && csr_ready_o && !csr_req_i.write;

   // Outputs quiet in the cycle after any reset cycle
   a_quiet_after_reset: assert property (@(posedge clk_i)
      rst_i |=> !axis_tready_o && !sys_valid_o && !csr_rvalid_o && !interrupt_o)
      else begin
         $error("Output active right after reset");
         fail_count++;
      end

   // Stalled input beat must be held
   a_axis_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      axis_tvalid_i && !axis_tready_o |=> axis_tvalid_i && $stable(axis_beat_i))
      else begin
         $error("axis beat changed while stalled");
         fail_count++;
      end

   a_sys_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      sys_valid_o && !sys_ready_i |=> sys_valid_o && $stable(sys_data_o))
      else begin
         $error("sys word changed while stalled");
         fail_count++;
      end

   // Read response exactly one cycle after acceptance
   a_rvalid_follows: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_accept |=> csr_rvalid_o)
      else begin
         $error("csr_rvalid_o missing after accepted read");
         fail_count++;
      end

   a_rvalid_only: assert property (@(posedge clk_i) disable iff (rst_i)
      !rd_accept |=> !csr_rvalid_o)
      else begin
         $error("csr_rvalid_o without accepted read");
         fail_count++;
      end

endmodule

bind axis_in axis_in_checker u_checker (.*);

// File: testbench/tb_axis_in.sv
`timescale 1ns/1ps
`include "axis_in_config.svh"

module tb_axis_in;

   localparam int BEATS_PER_WORD = `AXIS_IN_DATA_W / `AXIS_IN_TDATA_W;
   localparam int DEPTH = 1 << `AXIS_IN_FIFO_ADDR_W;
   // Tests take well under 1000 cycles so the limit leaves a wide margin
   localparam int MAX_CYCLES = 4000;

   logic                           clk = 1'b0;
   logic                           rst;
   logic                           axis_tvalid;
   logic                           axis_tready;
   axis_in_stream_pkg::axis_beat_t axis_beat;
   logic                           sys_valid;
   logic                           sys_ready;
   axis_in_stream_pkg::word_t      sys_data;
   logic                           csr_valid;
   logic                           csr_ready;
   axis_in_csr_pkg::csr_req_t      csr_req;
   logic                           csr_rvalid;
   axis_in_stream_pkg::word_t      csr_rdata;
   logic                           interrupt;

   integer                         seed;
   int                             cycle_count = 0;
   int                             beats_accepted;
   int                             data_idx;
   int                             stall;
   logic                           sys_hold;
   logic                           sys_random;
   logic                           ready_next;
   axis_in_stream_pkg::beat_t      rand_data [256];
   int                             burst_words [4];
   int                             burst_gap [4];
   int                             pkt_len [4] = '{1, 2, 3, 5};
   int                             thresholds [5] = '{1, 3, 5, 6, 8};
   axis_in_stream_pkg::axis_beat_t pkt [$];
   axis_in_stream_pkg::word_t      exp_q [$];
   axis_in_stream_pkg::word_t      exp_word;
   axis_in_stream_pkg::word_t      rd;
   axis_in_stream_pkg::level_t     exp_level;

   always #20 clk = ~clk;

   axis_in uut (
      .clk_i         (clk),
      .rst_i         (rst),
      .axis_tvalid_i (axis_tvalid),
      .axis_tready_o (axis_tready),
      .axis_beat_i   (axis_beat),
      .sys_valid_o   (sys_valid),
      .sys_ready_i   (sys_ready),
      .sys_data_o    (sys_data),
      .csr_valid_i   (csr_valid),
      .csr_ready_o   (csr_ready),
      .csr_req_i     (csr_req),
      .csr_rvalid_o  (csr_rvalid),
      .csr_rdata_o   (csr_rdata),
      .interrupt_o   (interrupt)
   );

   task automatic abort_run();
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_word(input axis_in_stream_pkg::word_t act,
                             input axis_in_stream_pkg::word_t exp, input string name);
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_count(input axis_in_stream_pkg::count_t act,
                              input axis_in_stream_pkg::count_t exp, input string name);
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_level(input axis_in_stream_pkg::level_t act,
                              input axis_in_stream_pkg::level_t exp, input string name);
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input logic act, input logic exp, input string name);
      if (act !== exp) begin
         $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   function automatic axis_in_stream_pkg::axis_beat_t make_beat(
      input axis_in_stream_pkg::beat_t data, input logic last);
      axis_in_stream_pkg::axis_beat_t b;
      b.tdata = data;
      b.tlast = last;
      return b;
   endfunction

   // Reference packer fills the lowest lane first and zeroes the lanes after a tlast
   function automatic void pack_ref(input axis_in_stream_pkg::axis_beat_t beats [$]);
      axis_in_stream_pkg::word_t word;
      int                        lane;
      word = '0;
      lane = 0;
      foreach (beats[i]) begin
         word[lane*`AXIS_IN_TDATA_W +: `AXIS_IN_TDATA_W] = beats[i].tdata;
         if (lane == BEATS_PER_WORD - 1 || beats[i].tlast) begin
            exp_q.push_back(word);
            word = '0;
            lane = 0;
         end else begin
            lane++;
         end
      end
   endfunction

   function automatic void add_beats(input int n, input logic tlast_at_end);
      for (int i = 0; i < n; i++) begin
         pkt.push_back(make_beat(rand_data[data_idx], tlast_at_end && (i == n - 1)));
         data_idx = (data_idx + 1) % 256;
      end
   endfunction

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic send_packet();
      foreach (pkt[i]) begin
         axis_tvalid = 1'b1;
         axis_beat   = pkt[i];
         do @(posedge clk); while (!axis_tready);
         beats_accepted++;
         #2;
      end
      axis_tvalid = 1'b0;
      pkt = {};
   endtask

   task automatic csr_write(input axis_in_csr_pkg::csr_addr_t addr,
                            input axis_in_stream_pkg::word_t data);
      csr_valid = 1'b1;
      csr_req   = '{write: 1'b1, addr: addr, wdata: data};
      do @(posedge clk); while (!csr_ready);
      #2;
      csr_valid = 1'b0;
   endtask

   task automatic csr_read(input axis_in_csr_pkg::csr_addr_t addr,
                           output axis_in_stream_pkg::word_t data);
      csr_valid = 1'b1;
      csr_req   = '{write: 1'b0, addr: addr, wdata: '0};
      do @(posedge clk); while (!csr_ready);
      #2;
      csr_valid = 1'b0;
      @(posedge clk);
      check_flag(csr_rvalid, 1'b1, "csr_rvalid_o");
      data = csr_rdata;
      #2;
   endtask

   task automatic soft_reset();
      csr_write(`AXIS_IN_ADDR_SOFT_RESET, 32'd1);
      idle(2);
   endtask

   task automatic read_data_word();
      axis_in_stream_pkg::word_t data;
      csr_read(`AXIS_IN_ADDR_DATA, data);
      if (exp_q.size() == 0) begin
         $display("DATA read at %0t returned a word that no beat produced", $time);
         abort_run();
      end
      check_word(data, exp_q.pop_front(), "csr_rdata_o");
   endtask

   task automatic wait_drain();
      do begin
         @(posedge clk);
         #2;
      end while (exp_q.size() != 0);
   endtask

   // Random back-pressure on sys is decided at the edge and driven after it
   always @(posedge clk) begin
      ready_next = sys_random ? 1'($random(seed)) : 1'b1;
      if (sys_hold) begin
         ready_next = 1'b0;
      end
      #2;
      sys_ready = ready_next;
   end

   // Compare every sys transfer with the reference words
   always @(posedge clk) begin
      if (!rst && sys_valid && sys_ready) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected word on the sys stream at %0t", $time);
            abort_run();
         end else begin
            exp_word = exp_q.pop_front();
            check_word(sys_data, exp_word, "sys_data_o");
         end
      end
   end

   always @(posedge clk) begin
      if (uut.u_checker.fail_count != 0) begin
         $display("A bound assertion failed before %0t", $time);
         abort_run();
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
         abort_run();
      end
   end

   initial begin
      seed           = 32'hd81c;
      rst            = 1'b1;
      axis_tvalid    = 1'b0;
      axis_beat      = '0;
      sys_ready      = 1'b0;
      csr_valid      = 1'b0;
      csr_req        = '0;
      sys_hold       = 1'b0;
      sys_random     = 1'b0;
      beats_accepted = 0;
      data_idx       = 0;
      foreach (rand_data[i]) begin
         rand_data[i] = axis_in_stream_pkg::beat_t'($random(seed));
      end
      foreach (burst_words[i]) begin
         burst_words[i] = 1 + ($random(seed) & 3);
         burst_gap[i]   = $random(seed) & 3;
      end

      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;
      check_flag(axis_tready, 1'b0, "axis_tready_o");
      check_flag(sys_valid, 1'b0, "sys_valid_o");
      check_flag(csr_rvalid, 1'b0, "csr_rvalid_o");
      check_flag(interrupt, 1'b0, "interrupt_o");

      // Stream mode with random bursts of whole words
      csr_write(`AXIS_IN_ADDR_ENABLE, 32'd1);
      csr_write(`AXIS_IN_ADDR_MODE, 32'd1);
      sys_random = 1'b1;
      for (int b = 0; b < 4; b++) begin
         add_beats(burst_words[b] * BEATS_PER_WORD, 1'b0);
         pack_ref(pkt);
         send_packet();
         idle(burst_gap[b]);
      end
      wait_drain();

      // Short packets padded on tlast
      foreach (pkt_len[i]) begin
         add_beats(pkt_len[i], 1'b1);
         pack_ref(pkt);
         send_packet();
      end
      wait_drain();

      // Fill the FIFO with sys stalled
      sys_hold       = 1'b1;
      beats_accepted = 0;
      add_beats(12 * BEATS_PER_WORD, 1'b0);
      pack_ref(pkt);
      fork
         send_packet();
         begin
            stall = 0;
            while (stall < 16) begin
               @(posedge clk);
               stall = (axis_tvalid && !axis_tready) ? stall + 1 : 0;
            end
            #2;
            check_flag(beats_accepted >= 9 * BEATS_PER_WORD, 1'b1, "axis_tready_o");
            csr_read(`AXIS_IN_ADDR_STATUS, rd);
            check_flag(rd[1], 1'b1, "status.full");
            csr_read(`AXIS_IN_ADDR_LEVEL, rd);
            check_level(rd[`AXIS_IN_FIFO_ADDR_W:0], DEPTH, "level");
            check_flag(interrupt, 1'b1, "interrupt_o");
            sys_hold = 1'b0;
         end
      join
      wait_drain();

      // Register mode stops after a tlast
      csr_write(`AXIS_IN_ADDR_MODE, 32'd0);
      soft_reset();
      add_beats(6, 1'b1);
      pack_ref(pkt);
      send_packet();
      idle(2);
      repeat (8) begin
         check_flag(axis_tready, 1'b0, "axis_tready_o");
         idle(1);
      end
      csr_read(`AXIS_IN_ADDR_STATUS, rd);
      check_flag(rd[2], 1'b1, "status.tlast_detected");
      check_flag(rd[1], 1'b0, "status.full");
      csr_read(`AXIS_IN_ADDR_NWORDS, rd);
      check_count(rd, 6, "nwords");
      read_data_word();
      read_data_word();

      // Interrupt against several thresholds
      soft_reset();
      add_beats(6 * BEATS_PER_WORD, 1'b1);
      pack_ref(pkt);
      send_packet();
      idle(6);
      // One word waits in the output stage and the rest sit in the FIFO
      exp_level = axis_in_stream_pkg::level_t'(exp_q.size() - 1);
      foreach (thresholds[i]) begin
         csr_write(`AXIS_IN_ADDR_THRESHOLD, 32'(thresholds[i]));
         csr_read(`AXIS_IN_ADDR_THRESHOLD, rd);
         check_level(rd[`AXIS_IN_FIFO_ADDR_W:0],
                     axis_in_stream_pkg::level_t'(thresholds[i]), "threshold");
         csr_read(`AXIS_IN_ADDR_LEVEL, rd);
         check_level(rd[`AXIS_IN_FIFO_ADDR_W:0], exp_level, "level");
         check_flag(interrupt, exp_level >= thresholds[i], "interrupt_o");
      end
      repeat (6) read_data_word();
      csr_read(`AXIS_IN_ADDR_LEVEL, rd);
      check_level(rd[`AXIS_IN_FIFO_ADDR_W:0], '0, "level");

      // Soft reset drops stored words and a partial word
      soft_reset();
      csr_read(`AXIS_IN_ADDR_STATUS, rd);
      check_flag(rd[2], 1'b0, "status.tlast_detected");
      add_beats(2 * BEATS_PER_WORD + 2, 1'b0);
      send_packet();
      idle(4);
      soft_reset();
      csr_read(`AXIS_IN_ADDR_STATUS, rd);
      check_flag(rd[0], 1'b1, "status.empty");
      csr_read(`AXIS_IN_ADDR_LEVEL, rd);
      check_level(rd[`AXIS_IN_FIFO_ADDR_W:0], '0, "level");
      csr_read(`AXIS_IN_ADDR_NWORDS, rd);
      check_count(rd, '0, "nwords");
      add_beats(3, 1'b1);
      pack_ref(pkt);
      send_packet();
      read_data_word();

      idle(4);
      if (exp_q.size() == 0 && uut.u_checker.fail_count == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display("%0d words missing, %0d assertion failures",
                  exp_q.size(), uut.u_checker.fail_count);
         $display(">>> FAIL");
         $fatal(1, "Simulation ended with errors");
      end
   end

endmodule

// File: axis_in.f
+incdir+hdl
hdl/axis_in_stream_pkg.sv
hdl/axis_in_csr_pkg.sv
hdl/axis_in_csrs.sv
hdl/axis_in_pack.sv
hdl/axis_in_fifo.sv
hdl/axis_in_drain.sv
hdl/axis_in.sv
testbench/axis_in_checker.sv
testbench/tb_axis_in.sv

// File: Bender.yml
package:
  name: axis_in

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axis_in_stream_pkg.sv
      - hdl/axis_in_csr_pkg.sv
      - hdl/axis_in_csrs.sv
      - hdl/axis_in_pack.sv
      - hdl/axis_in_fifo.sv
      - hdl/axis_in_drain.sv
      - hdl/axis_in.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/axis_in_checker.sv
      - testbench/tb_axis_in.sv
